// ==== hw/exec_cluster.sv ====
`timescale 1ns/1ps

module exec_cluster #(
  parameter int DATA_W = exec_pkg::DATA_W_DEFAULT,
  parameter int MUL_BITS_PER_STEP = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              issue_0,
  input  exec_pkg::op_t     op_0,
  input  logic [DATA_W-1:0] a_reg_0,
  input  logic [DATA_W-1:0] b_reg_0,
  input  fwd_pkg::src_t     a_src_0,
  input  fwd_pkg::src_t     b_src_0,
  input  logic              issue_1,
  input  exec_pkg::op_t     op_1,
  input  logic [DATA_W-1:0] a_reg_1,
  input  logic [DATA_W-1:0] b_reg_1,
  input  fwd_pkg::src_t     a_src_1,
  input  fwd_pkg::src_t     b_src_1,
  output logic [DATA_W-1:0] result_0,
  output logic              result_valid_0,
  output logic [DATA_W-1:0] result_1,
  output logic              result_valid_1,
  output logic [DATA_W-1:0] mul_result,
  output logic              mul_done,
  output logic              mul_busy
);

  logic [fwd_pkg::NUM_LANES-1:0][DATA_W-1:0] bus_old;
  logic [DATA_W-1:0] a_op_0;
  logic [DATA_W-1:0] b_op_0;
  logic [DATA_W-1:0] a_op_1;
  logic [DATA_W-1:0] b_op_1;
  logic              mul_start;
  logic [DATA_W-1:0] mul_a;
  logic [DATA_W-1:0] mul_b;
  logic              mul_load;
  logic              mul_step;
  logic              mul_last;

  // ********************************************************************
  // Forwarding network.
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      bus_old <= '0;
    end else begin
      bus_old <= {result_1, result_0};  // Each bus as it stood one cycle back.
    end
  end

  operand_forward #(.DATA_W(DATA_W)) a_fwd_0 (
    .src(a_src_0), .reg_val(a_reg_0), .bus0(result_0), .bus1(result_1),
    .old0(bus_old[0]), .old1(bus_old[1]), .operand(a_op_0));
  operand_forward #(.DATA_W(DATA_W)) b_fwd_0 (
    .src(b_src_0), .reg_val(b_reg_0), .bus0(result_0), .bus1(result_1),
    .old0(bus_old[0]), .old1(bus_old[1]), .operand(b_op_0));
  operand_forward #(.DATA_W(DATA_W)) a_fwd_1 (
    .src(a_src_1), .reg_val(a_reg_1), .bus0(result_0), .bus1(result_1),
    .old0(bus_old[0]), .old1(bus_old[1]), .operand(a_op_1));
  operand_forward #(.DATA_W(DATA_W)) b_fwd_1 (
    .src(b_src_1), .reg_val(b_reg_1), .bus0(result_0), .bus1(result_1),
    .old0(bus_old[0]), .old1(bus_old[1]), .operand(b_op_1));

  // ********************************************************************
  // Lanes and the multiplier behind lane 1.
  // ********************************************************************
  int_lane #(.DATA_W(DATA_W)) lane_0 (
    .clk(clk), .reset(reset), .issue(issue_0), .op(op_0), .a(a_op_0), .b(b_op_0),
    .result(result_0), .result_valid(result_valid_0),
    .mul_start(), .mul_a(), .mul_b());

  int_lane #(.DATA_W(DATA_W)) lane_1 (
    .clk(clk), .reset(reset), .issue(issue_1), .op(op_1), .a(a_op_1), .b(b_op_1),
    .result(result_1), .result_valid(result_valid_1),
    .mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b));

  mul_sequencer mul_seq (
    .clk(clk), .reset(reset), .start(mul_start), .last(mul_last),
    .load(mul_load), .step(mul_step), .done(mul_done), .busy(mul_busy));

  mul_step_counter #(.DATA_W(DATA_W), .MUL_BITS_PER_STEP(MUL_BITS_PER_STEP)) mul_cnt (
    .clk(clk), .reset(reset), .load(mul_load), .step(mul_step), .last(mul_last));

  mul_datapath #(.DATA_W(DATA_W), .MUL_BITS_PER_STEP(MUL_BITS_PER_STEP)) mul_dp (
    .clk(clk), .load(mul_load), .step(mul_step), .a(mul_a), .b(mul_b),
    .product(mul_result));

  // Only lane 1 is wired to the multiplier.
  a_no_mul_lane_0: assert property (@(posedge clk) disable iff (reset)
    issue_0 |-> op_0 != exec_pkg::OP_MUL);

endmodule

// ==== hw/exec_pkg.sv ====
package exec_pkg;

  localparam int DATA_W_DEFAULT = 64;
  localparam int OP_W = 4;

  // 32-bit forms work on the low word and zero-extend the result.
  localparam int WORD_W = 32;
  localparam int SHAMT_W = 6;       // Shift amount bits in 64-bit form.
  localparam int WORD_SHAMT_W = 5;  // Shift amount bits in 32-bit form.

  typedef enum logic [OP_W-1:0] {
    OP_NOP,
    OP_ADD64,
    OP_ADD32,
    OP_SUB64,
    OP_SUB32,
    OP_SHL64,
    OP_SHL32,
    OP_SHR64,
    OP_SHR32,
    OP_SAR64,
    OP_SAR32,
    OP_MUL
  } op_t;

  // States of the iterative multiplier.
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } mul_state_t;

  function automatic int mul_steps(input int data_w, input int bits_per_step);
    return data_w / bits_per_step;
  endfunction

endpackage

// ==== hw/fwd_pkg.sv ====
package fwd_pkg;

  localparam int NUM_LANES = 2;

  // Where an operand comes from at issue.
  typedef enum logic [2:0] {
    SRC_REG,   // Register value given with the issue.
    SRC_BUS0,  // Lane 0 result bus, this cycle.
    SRC_BUS1,  // Lane 1 result bus, this cycle.
    SRC_OLD0,  // Lane 0 result bus, one cycle back.
    SRC_OLD1   // Lane 1 result bus, one cycle back.
  } src_t;

endpackage

// ==== hw/int_lane.sv ====
`timescale 1ns/1ps

module int_lane #(
  parameter int DATA_W = exec_pkg::DATA_W_DEFAULT
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              issue,
  input  exec_pkg::op_t     op,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  output logic [DATA_W-1:0] result,
  output logic              result_valid,
  output logic              mul_start,
  output logic [DATA_W-1:0] mul_a,
  output logic [DATA_W-1:0] mul_b
);

  localparam int W = exec_pkg::WORD_W;
  localparam int SH_W = exec_pkg::SHAMT_W;

  logic              valid_q;
  exec_pkg::op_t     op_q;
  logic [DATA_W-1:0] a_q;
  logic [DATA_W-1:0] b_q;
  logic              is_sub;
  logic              shift_left;
  logic              arith;
  logic              shift_op;
  logic              is32;
  logic              produce;
  logic [SH_W-1:0]   amt;
  logic [DATA_W-1:0] shift_src;
  logic [DATA_W-1:0] sum;
  logic [DATA_W-1:0] shr_val;
  logic [DATA_W-1:0] sar_val;
  logic [DATA_W-1:0] raw;

  // ********************************************************************
  // Issue register.
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue;
    end
    if (issue) begin
      op_q <= op;
      a_q  <= a;
      b_q  <= b;
    end
  end

  assign is_sub     = op_q inside {exec_pkg::OP_SUB64, exec_pkg::OP_SUB32};
  assign shift_left = op_q inside {exec_pkg::OP_SHL64, exec_pkg::OP_SHL32};
  assign arith      = op_q inside {exec_pkg::OP_SAR64, exec_pkg::OP_SAR32};
  assign shift_op   = shift_left || arith ||
                      op_q inside {exec_pkg::OP_SHR64, exec_pkg::OP_SHR32};
  assign is32       = op_q inside {exec_pkg::OP_ADD32, exec_pkg::OP_SUB32, exec_pkg::OP_SHL32,
                                   exec_pkg::OP_SHR32, exec_pkg::OP_SAR32};

  // Word shifts take five amount bits and see only the low word of A.
  assign amt = is32 ? SH_W'(b_q[exec_pkg::WORD_SHAMT_W-1:0]) : b_q[SH_W-1:0];
  assign shift_src = !is32 ? a_q :
                     arith ? {{(DATA_W-W){a_q[W-1]}}, a_q[W-1:0]} : DATA_W'(a_q[W-1:0]);

  assign sum     = a_q + (is_sub ? ~b_q : b_q) + DATA_W'(is_sub);
  assign shr_val = shift_src >> amt;
  assign sar_val = $signed(shift_src) >>> amt;
  assign raw     = !shift_op  ? sum :
                   shift_left ? shift_src << amt :
                   arith      ? sar_val : shr_val;

  assign produce = valid_q && !(op_q inside {exec_pkg::OP_NOP, exec_pkg::OP_MUL});

  // ********************************************************************
  // Result register, one edge after issue.
  // ********************************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= produce;
      if (produce) result <= is32 ? DATA_W'(raw[W-1:0]) : raw;
    end
  end

  // A multiply leaves the lane from the issue register straight away.
  assign mul_start = valid_q && op_q == exec_pkg::OP_MUL;
  assign mul_a     = a_q;
  assign mul_b     = b_q;

endmodule

// ==== hw/mul_datapath.sv ====
`timescale 1ns/1ps

module mul_datapath #(
  parameter int DATA_W = 64,
  parameter int MUL_BITS_PER_STEP = 4
) (
  input  logic              clk,
  input  logic              load,
  input  logic              step,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  output logic [DATA_W-1:0] product
);

  logic [DATA_W-1:0] mcand;
  logic [DATA_W-1:0] mplier;
  logic [DATA_W-1:0] acc;
  logic [DATA_W-1:0] partial;

  // Only the low DATA_W bits of the product are kept, so every term wraps.
  assign partial = mcand * DATA_W'(mplier[MUL_BITS_PER_STEP-1:0]);

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= a;
      mplier <= b;
      acc    <= '0;
    end else if (step) begin
      acc    <= acc + partial;
      mcand  <= mcand << MUL_BITS_PER_STEP;
      mplier <= mplier >> MUL_BITS_PER_STEP;
    end
  end

  assign product = acc;

endmodule

// ==== hw/mul_sequencer.sv ====
`timescale 1ns/1ps

module mul_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic last,
  output logic load,
  output logic step,
  output logic done,
  output logic busy
);

  exec_pkg::mul_state_t state;
  exec_pkg::mul_state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= exec_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      exec_pkg::ST_IDLE: if (start) state_next = exec_pkg::ST_RUN;
      exec_pkg::ST_RUN:  if (last) state_next = exec_pkg::ST_DONE;
      default:           state_next = exec_pkg::ST_IDLE;
    endcase
  end

  assign load = state == exec_pkg::ST_IDLE && start;
  assign step = state == exec_pkg::ST_RUN;   // One partial product per cycle.
  assign done = state == exec_pkg::ST_DONE;
  assign busy = state != exec_pkg::ST_IDLE;

  // The issuing lane has to wait for the previous multiply to finish.
  a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
    start |-> !busy);

  a_done_to_idle: assert property (@(posedge clk) disable iff (reset)
    done |=> state == exec_pkg::ST_IDLE && !done);

endmodule

// ==== hw/mul_step_counter.sv ====
`timescale 1ns/1ps

module mul_step_counter #(
  parameter int DATA_W = exec_pkg::DATA_W_DEFAULT,
  parameter int MUL_BITS_PER_STEP = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic step,
  output logic last
);

  localparam int STEPS = exec_pkg::mul_steps(DATA_W, MUL_BITS_PER_STEP);
  localparam int CNT_W = $clog2(STEPS + 1);

  logic [CNT_W-1:0] remaining;

  always_ff @(posedge clk) begin
    if (reset) begin
      remaining <= '0;
    end else if (load) begin
      remaining <= CNT_W'(STEPS);
    end else if (step && remaining != '0) begin
      remaining <= remaining - 1'b1;
    end
  end

  assign last = remaining == CNT_W'(1);  // The step now running is the final one.

endmodule

// ==== hw/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward #(
  parameter int DATA_W = 64
) (
  input  fwd_pkg::src_t     src,
  input  logic [DATA_W-1:0] reg_val,
  input  logic [DATA_W-1:0] bus0,
  input  logic [DATA_W-1:0] bus1,
  input  logic [DATA_W-1:0] old0,
  input  logic [DATA_W-1:0] old1,
  output logic [DATA_W-1:0] operand
);

  always_comb begin
    case (src)
      fwd_pkg::SRC_REG:  operand = reg_val;
      fwd_pkg::SRC_BUS0: operand = bus0;
      fwd_pkg::SRC_BUS1: operand = bus1;
      fwd_pkg::SRC_OLD0: operand = old0;
      fwd_pkg::SRC_OLD1: operand = old1;
      default:           operand = reg_val;
    endcase
  end

  // The three-bit select has codes with no source behind them.
  always_comb begin
    assert (src inside {fwd_pkg::SRC_REG, fwd_pkg::SRC_BUS0, fwd_pkg::SRC_BUS1,
                        fwd_pkg::SRC_OLD0, fwd_pkg::SRC_OLD1})
      else $error("operand_forward: illegal source select %0d", src);
  end

endmodule

// ==== project.f ====
hw/exec_pkg.sv
hw/fwd_pkg.sv
hw/operand_forward.sv
hw/int_lane.sv
hw/mul_sequencer.sv
hw/mul_step_counter.sv
hw/mul_datapath.sv
hw/exec_cluster.sv
tb/exec_cluster_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f project.f \
       --top-module exec_cluster_tb -o exec_cluster_sim \
  && ./obj_dir/exec_cluster_sim | tee /dev/stderr | grep -q "All tests passed" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// ==== tb/exec_cluster_tb.sv ====
`timescale 1ns/1ps

module exec_cluster_tb;

  localparam int DATA_W = exec_pkg::DATA_W_DEFAULT;
  localparam int N_ARITH = 200;
  localparam int N_SHIFT = 200;
  localparam int N_FWD = 300;
  localparam int N_MUL = 30;
  // Issues and multiplies need about 1300 cycles; the limit leaves wide margin.
  localparam int MAX_CYCLES = 4000;

  logic              clk;
  logic              reset;
  logic              issue_0;
  exec_pkg::op_t     op_0;
  logic [DATA_W-1:0] a_reg_0;
  logic [DATA_W-1:0] b_reg_0;
  fwd_pkg::src_t     a_src_0;
  fwd_pkg::src_t     b_src_0;
  logic              issue_1;
  exec_pkg::op_t     op_1;
  logic [DATA_W-1:0] a_reg_1;
  logic [DATA_W-1:0] b_reg_1;
  fwd_pkg::src_t     a_src_1;
  fwd_pkg::src_t     b_src_1;
  logic [DATA_W-1:0] result_0;
  logic              result_valid_0;
  logic [DATA_W-1:0] result_1;
  logic              result_valid_1;
  logic [DATA_W-1:0] mul_result;
  logic              mul_done;
  logic              mul_busy;

  logic [31:0]       rng_state;
  int                cycles;
  logic              issued;
  logic              s1_valid [2];
  logic [DATA_W-1:0] s1_res [2];
  logic              exp_valid [2];
  logic [DATA_W-1:0] m_bus [2];
  logic [DATA_W-1:0] m_old [2];
  logic [DATA_W-1:0] mul_exp;

  exec_cluster dut_i (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic exec_pkg::op_t pick_op(input int first, input int count);
    return exec_pkg::op_t'(first + int'(rand32() % count));
  endfunction

  // ********************************************************************
  // Reference model of the op rules and the forwarding network.
  // ********************************************************************
  function automatic logic [DATA_W-1:0] model_alu(input exec_pkg::op_t op,
                                                  input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
    logic [31:0] a32;
    logic [31:0] b32;
    a32 = a[31:0];
    b32 = b[31:0];
    case (op)
      exec_pkg::OP_ADD64: return a + b;
      exec_pkg::OP_ADD32: return {32'h0, a32 + b32};
      exec_pkg::OP_SUB64: return a - b;
      exec_pkg::OP_SUB32: return {32'h0, a32 - b32};
      exec_pkg::OP_SHL64: return a << b[5:0];
      exec_pkg::OP_SHL32: return {32'h0, a32 << b[4:0]};
      exec_pkg::OP_SHR64: return a >> b[5:0];
      exec_pkg::OP_SHR32: return {32'h0, a32 >> b[4:0]};
      exec_pkg::OP_SAR64: return $signed(a) >>> b[5:0];
      exec_pkg::OP_SAR32: return {32'h0, $signed(a32) >>> b[4:0]};
      default:            return '0;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] fwd_pick(input fwd_pkg::src_t src,
                                                 input logic [DATA_W-1:0] reg_val);
    case (src)
      fwd_pkg::SRC_BUS0: return m_bus[0];
      fwd_pkg::SRC_BUS1: return m_bus[1];
      fwd_pkg::SRC_OLD0: return m_old[0];
      fwd_pkg::SRC_OLD1: return m_old[1];
      default:           return reg_val;
    endcase
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      issued <= 1'b0;
      for (int k = 0; k < 2; k++) begin
        s1_valid[k]  <= 1'b0;
        exp_valid[k] <= 1'b0;
        m_bus[k]     <= '0;
        m_old[k]     <= '0;
      end
    end else begin
      if (issue_0 || issue_1) issued <= 1'b1;
      s1_valid[0] <= issue_0;
      s1_res[0]   <= model_alu(op_0, fwd_pick(a_src_0, a_reg_0), fwd_pick(b_src_0, b_reg_0));
      s1_valid[1] <= issue_1 && op_1 != exec_pkg::OP_MUL;
      s1_res[1]   <= model_alu(op_1, fwd_pick(a_src_1, a_reg_1), fwd_pick(b_src_1, b_reg_1));
      if (issue_1 && op_1 == exec_pkg::OP_MUL) begin
        mul_exp <= fwd_pick(a_src_1, a_reg_1) * fwd_pick(b_src_1, b_reg_1);
      end
      for (int k = 0; k < 2; k++) begin
        exp_valid[k] <= s1_valid[k];
        m_old[k]     <= m_bus[k];   // Delayed copy follows the bus every cycle.
        if (s1_valid[k]) m_bus[k] <= s1_res[k];
      end
    end
  end

  // ********************************************************************
  // Checks.
  // ********************************************************************
  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] expected,
                                 input logic [DATA_W-1:0] actual);
    $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    $display("Some tests failed");
    $fatal(1);
  endtask

  a_idle_after_reset: assert property (@(posedge clk) disable iff (reset)
    !issued |-> !(result_valid_0 || result_valid_1 || mul_busy || mul_done))
    else report_mismatch("idle after reset", 0,
                         $sampled({result_valid_0, result_valid_1, mul_busy, mul_done}));
  a_valid_0: assert property (@(posedge clk) disable iff (reset)
    result_valid_0 == exp_valid[0])
    else report_mismatch("lane 0 valid", $sampled(exp_valid[0]), $sampled(result_valid_0));
  a_valid_1: assert property (@(posedge clk) disable iff (reset)
    result_valid_1 == exp_valid[1])
    else report_mismatch("lane 1 valid", $sampled(exp_valid[1]), $sampled(result_valid_1));
  a_bus_0: assert property (@(posedge clk) disable iff (reset) result_0 == m_bus[0])
    else report_mismatch("lane 0 result", $sampled(m_bus[0]), $sampled(result_0));
  a_bus_1: assert property (@(posedge clk) disable iff (reset) result_1 == m_bus[1])
    else report_mismatch("lane 1 result", $sampled(m_bus[1]), $sampled(result_1));
  a_mul_result: assert property (@(posedge clk) disable iff (reset)
    mul_done |-> mul_result == mul_exp)
    else report_mismatch("multiply result", $sampled(mul_exp), $sampled(mul_result));
  a_mul_busy_rise: assert property (@(posedge clk) disable iff (reset)
    issue_1 && op_1 == exec_pkg::OP_MUL |-> ##2 mul_busy)
    else report_mismatch("busy after multiply issue", 1, $sampled(mul_busy));
  a_mul_busy_hold: assert property (@(posedge clk) disable iff (reset)
    mul_busy && !mul_done |=> mul_busy)
    else report_mismatch("busy held until done", 1, $sampled(mul_busy));
  a_mul_done_busy: assert property (@(posedge clk) disable iff (reset)
    mul_done |-> mul_busy)
    else report_mismatch("busy during done", 1, $sampled(mul_busy));
  a_mul_busy_release: assert property (@(posedge clk) disable iff (reset)
    mul_done |=> !(mul_busy || mul_done))
    else report_mismatch("busy released after done", 0, $sampled(mul_busy));

  // ********************************************************************
  // Clock, timeout and stimulus.
  // ********************************************************************
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $fatal(1);
    end
  end

  task automatic drive_lane(input int lane, input logic go, input exec_pkg::op_t op,
                            input fwd_pkg::src_t a_src, input fwd_pkg::src_t b_src);
    if (lane == 0) begin
      issue_0 <= go;
      op_0    <= op;
      a_reg_0 <= {rand32(), rand32()};
      b_reg_0 <= {rand32(), rand32()};
      a_src_0 <= a_src;
      b_src_0 <= b_src;
    end else begin
      issue_1 <= go;
      op_1    <= op;
      a_reg_1 <= {rand32(), rand32()};
      b_reg_1 <= {rand32(), rand32()};
      a_src_1 <= a_src;
      b_src_1 <= b_src;
    end
  endtask

  function automatic fwd_pkg::src_t pick_src();
    return fwd_pkg::src_t'(rand32() % 5);
  endfunction

  initial begin
    logic done_seen;
    rng_state = 32'h7c84_2aef;
    cycles = 0;
    reset = 1'b1;
    issue_0 = 1'b0;
    op_0 = exec_pkg::OP_NOP;
    a_reg_0 = '0;
    b_reg_0 = '0;
    a_src_0 = fwd_pkg::SRC_REG;
    b_src_0 = fwd_pkg::SRC_REG;
    issue_1 = 1'b0;
    op_1 = exec_pkg::OP_NOP;
    a_reg_1 = '0;
    b_reg_1 = '0;
    a_src_1 = fwd_pkg::SRC_REG;
    b_src_1 = fwd_pkg::SRC_REG;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);

    for (int i = 0; i < N_ARITH; i++) begin
      @(posedge clk);
      drive_lane(0, 1'b1, pick_op(1, 4), fwd_pkg::SRC_REG, fwd_pkg::SRC_REG);
      drive_lane(1, 1'b1, pick_op(1, 4), fwd_pkg::SRC_REG, fwd_pkg::SRC_REG);
    end
    for (int i = 0; i < N_SHIFT; i++) begin
      @(posedge clk);
      drive_lane(0, 1'b1, pick_op(5, 6), fwd_pkg::SRC_REG, fwd_pkg::SRC_REG);
      drive_lane(1, 1'b1, pick_op(5, 6), fwd_pkg::SRC_REG, fwd_pkg::SRC_REG);
    end
    for (int i = 0; i < N_FWD; i++) begin
      @(posedge clk);
      drive_lane(0, 1'b1, pick_op(1, 10), pick_src(), pick_src());
      drive_lane(1, 1'b1, pick_op(1, 10), pick_src(), pick_src());
    end

    // Lane 0 keeps issuing while each multiply runs on lane 1.
    for (int m = 0; m < N_MUL; m++) begin
      @(posedge clk);
      drive_lane(1, 1'b1, exec_pkg::OP_MUL, fwd_pkg::SRC_REG, fwd_pkg::SRC_REG);
      drive_lane(0, 1'b1, pick_op(1, 10), pick_src(), pick_src());
      done_seen = 1'b0;
      while (!done_seen) begin
        @(posedge clk);
        done_seen = mul_done;
        drive_lane(1, 1'b0, exec_pkg::OP_NOP, fwd_pkg::SRC_REG, fwd_pkg::SRC_REG);
        drive_lane(0, 1'b1, pick_op(1, 10), pick_src(), pick_src());
      end
    end

    @(posedge clk);
    drive_lane(0, 1'b0, exec_pkg::OP_NOP, fwd_pkg::SRC_REG, fwd_pkg::SRC_REG);
    repeat (4) @(posedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule
